// ==== src/rtx_pkg.sv ====
package rtx_pkg;

  // Q8.8 signed coordinate used for all ray geometry
  localparam int FIX_FRAC = 8;
  typedef logic signed [15:0] fix16;

  // fp24 layout: sign, 7-bit exponent, 16-bit mantissa with hidden one
  localparam int FP24_EXP_W  = 7;
  localparam int FP24_MANT_W = 16;
  localparam int FP24_BIAS   = 63;
  typedef logic [23:0] fp24;

  // scene slot index and raster coordinates
  typedef logic [1:0] obj_idx_t;
  typedef logic [3:0] pix_h_t;
  typedef logic [3:0] pix_v_t;

  // packed output pixel, blue in the top bits and red at the bottom
  typedef logic [15:0] rgb565_t;

  // image and scene size
  localparam int IMG_W   = 16;
  localparam int IMG_H   = 12;
  localparam int NUM_OBJ = 4;

  // per-pixel direction offset, 0.0625 in Q8.8
  localparam fix16 PIXEL_STEP = fix16'(1 << (FIX_FRAC - 4));

  // background colour when no sphere is hit
  // 0.125, 0.25 and 0.5
  localparam fp24 BG_R = 24'h3c0000;
  localparam fp24 BG_G = 24'h3d0000;
  localparam fp24 BG_B = 24'h3e0000;

  // tracer FSM
  typedef enum logic [1:0] {
    idle,
    fetch,
    test,
    done
  } tracer_state_t;

endpackage

// ==== src/scene_buffer.sv ====
`timescale 1ns/1ps

module scene_buffer import rtx_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // write port from outside
  input  logic     obj_we,
  input  obj_idx_t obj_addr,
  input  logic     obj_enable,
  input  fix16     obj_cx,
  input  fix16     obj_cy,
  input  fix16     obj_cz,
  input  fix16     obj_radius,
  input  fp24      obj_r,
  input  fp24      obj_g,
  input  fp24      obj_b,
  // registered read port for the tracer
  input  obj_idx_t rd_idx,
  output logic     rd_enable,
  output fix16     rd_cx,
  output fix16     rd_cy,
  output fix16     rd_cz,
  output fix16     rd_radius,
  output fp24      rd_r,
  output fp24      rd_g,
  output fp24      rd_b
);

  logic en_q  [NUM_OBJ];
  fix16 cx_q  [NUM_OBJ];
  fix16 cy_q  [NUM_OBJ];
  fix16 cz_q  [NUM_OBJ];
  fix16 rad_q [NUM_OBJ];
  fp24  r_q   [NUM_OBJ];
  fp24  g_q   [NUM_OBJ];
  fp24  b_q   [NUM_OBJ];

  // enable bits clear on reset so the scene starts empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_OBJ; i++) begin
        en_q[i] <= 1'b0;
      end
      rd_enable <= 1'b0;
    end else begin
      if (obj_we) begin
        en_q[obj_addr] <= obj_enable;
      end
      rd_enable <= en_q[rd_idx];
    end
  end

  // sphere geometry and colour
  always_ff @(posedge clk) begin
    if (obj_we) begin
      cx_q[obj_addr]  <= obj_cx;
      cy_q[obj_addr]  <= obj_cy;
      cz_q[obj_addr]  <= obj_cz;
      rad_q[obj_addr] <= obj_radius;
      r_q[obj_addr]   <= obj_r;
      g_q[obj_addr]   <= obj_g;
      b_q[obj_addr]   <= obj_b;
    end
    // data appears one cycle after rd_idx
    rd_cx     <= cx_q[rd_idx];
    rd_cy     <= cy_q[rd_idx];
    rd_cz     <= cz_q[rd_idx];
    rd_radius <= rad_q[rd_idx];
    rd_r      <= r_q[rd_idx];
    rd_g      <= g_q[rd_idx];
    rd_b      <= b_q[rd_idx];
  end

endmodule

// ==== src/ray_caster.sv ====
`timescale 1ns/1ps

module ray_caster import rtx_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   new_ray,
  // camera position and centre direction
  input  fix16   cam_x,
  input  fix16   cam_y,
  input  fix16   cam_z,
  input  fix16   cam_dx,
  input  fix16   cam_dy,
  input  fix16   cam_dz,
  // ray for the current pixel
  output logic   ray_valid,
  output pix_h_t ray_h,
  output pix_v_t ray_v,
  output fix16   org_x,
  output fix16   org_y,
  output fix16   org_z,
  output fix16   dir_x,
  output fix16   dir_y,
  output fix16   dir_z,
  output logic   last_pixel
);

  // raster position of the next ray
  pix_h_t h_q;
  pix_v_t v_q;

  fix16 off_h;
  fix16 off_v;
  logic at_end_h;
  logic at_end_v;

  // signed pixel offsets from the image centre, y grows upward
  assign off_h = fix16'({12'd0, h_q}) - fix16'(IMG_W / 2);
  assign off_v = fix16'(IMG_H / 2) - fix16'({12'd0, v_q});

  assign at_end_h = (h_q == pix_h_t'(IMG_W - 1));
  assign at_end_v = (v_q == pix_v_t'(IMG_H - 1));

  // raster walk, wraps to 0,0 after the last pixel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_q        <= '0;
      v_q        <= '0;
      ray_valid  <= 1'b0;
      last_pixel <= 1'b0;
    end else begin
      ray_valid <= new_ray;
      if (new_ray) begin
        last_pixel <= at_end_h && at_end_v;
        if (at_end_h) begin
          h_q <= '0;
          v_q <= at_end_v ? '0 : v_q + 1'b1;
        end else begin
          h_q <= h_q + 1'b1;
        end
      end
    end
  end

  // ray payload, held until the next request
  always_ff @(posedge clk) begin
    if (new_ray) begin
      ray_h <= h_q;
      ray_v <= v_q;
      org_x <= cam_x;
      org_y <= cam_y;
      org_z <= cam_z;
      // all sums wrap in 16 bits
      dir_x <= cam_dx + fix16'(off_h * PIXEL_STEP);
      dir_y <= cam_dy + fix16'(off_v * PIXEL_STEP);
      dir_z <= cam_dz;
    end
  end

endmodule

// ==== src/ray_tracer.sv ====
`timescale 1ns/1ps

module ray_tracer import rtx_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // ray from the caster
  input  logic     ray_valid,
  input  pix_h_t   ray_h,
  input  pix_v_t   ray_v,
  input  fix16     org_x,
  input  fix16     org_y,
  input  fix16     org_z,
  input  fix16     dir_x,
  input  fix16     dir_y,
  input  fix16     dir_z,
  input  logic     last_in,
  // scene read port
  output obj_idx_t rd_idx,
  input  logic     rd_enable,
  input  fix16     rd_cx,
  input  fix16     rd_cy,
  input  fix16     rd_cz,
  input  fix16     rd_radius,
  input  fp24      rd_r,
  input  fp24      rd_g,
  input  fp24      rd_b,
  // result
  output logic     trace_done,
  output fp24      color_r,
  output fp24      color_g,
  output fp24      color_b,
  output pix_h_t   pix_h,
  output pix_v_t   pix_v,
  output logic     last_out
);

  tracer_state_t state;
  obj_idx_t      idx;
  logic          hit_any;

  // latched ray
  fix16 ox_q;
  fix16 oy_q;
  fix16 oz_q;
  fix16 dx_q;
  fix16 dy_q;
  fix16 dz_q;

  // nearest hit so far, as the pair b and a
  logic signed [39:0] best_a;
  logic signed [39:0] best_b;

  // per-slot test terms
  logic signed [16:0] ocx;
  logic signed [16:0] ocy;
  logic signed [16:0] ocz;
  logic signed [39:0] a_v;
  logic signed [39:0] b_v;
  logic signed [39:0] c_v;
  logic signed [79:0] bb;
  logic signed [79:0] ac;
  logic signed [79:0] cross_new;
  logic signed [79:0] cross_old;
  logic               hit;
  logic               closer;
  logic               take;
  logic               last_slot;

  assign rd_idx     = idx;
  assign trace_done = (state == done);
  assign last_slot  = (idx == obj_idx_t'(NUM_OBJ - 1));

  // vector from ray origin to sphere centre
  assign ocx = rd_cx - ox_q;
  assign ocy = rd_cy - oy_q;
  assign ocz = rd_cz - oz_q;

  // quadratic terms, full width so nothing overflows
  assign a_v = dx_q * dx_q + dy_q * dy_q + dz_q * dz_q;
  assign b_v = ocx * dx_q + ocy * dy_q + ocz * dz_q;
  assign c_v = ocx * ocx + ocy * ocy + ocz * ocz - rd_radius * rd_radius;

  // sphere in front of the ray and discriminant not negative
  assign bb  = b_v * b_v;
  assign ac  = a_v * c_v;
  assign hit = rd_enable && (b_v > 0) && (bb >= ac);

  // smaller b/a is nearer, compared by cross products
  // strict compare so ties keep the lower index
  assign cross_new = b_v * best_a;
  assign cross_old = best_b * a_v;
  assign closer    = !hit_any || (cross_new < cross_old);
  assign take      = (state == test) && hit && closer;

  // control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      idx     <= '0;
      hit_any <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (ray_valid) begin
            idx     <= '0;
            hit_any <= 1'b0;
            state   <= fetch;
          end
        end
        // rd_idx is presented, data returns next cycle
        fetch: begin
          state <= test;
        end
        test: begin
          if (take) begin
            hit_any <= 1'b1;
          end
          if (last_slot) begin
            state <= done;
          end else begin
            idx   <= idx + 1'b1;
            state <= fetch;
          end
        end
        // one cycle with trace_done high
        done: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ray, best hit and colour
  // colour starts as background and is replaced on each nearer hit
  always_ff @(posedge clk) begin
    if (state == idle && ray_valid) begin
      ox_q     <= org_x;
      oy_q     <= org_y;
      oz_q     <= org_z;
      dx_q     <= dir_x;
      dy_q     <= dir_y;
      dz_q     <= dir_z;
      pix_h    <= ray_h;
      pix_v    <= ray_v;
      last_out <= last_in;
      color_r  <= BG_R;
      color_g  <= BG_G;
      color_b  <= BG_B;
    end else if (take) begin
      best_a  <= a_v;
      best_b  <= b_v;
      color_r <= rd_r;
      color_g <= rd_g;
      color_b <= rd_b;
    end
  end

endmodule

// ==== src/fp24_to_uint.sv ====
`timescale 1ns/1ps

module fp24_to_uint import rtx_pkg::*; #(
  parameter int WIDTH = 5,
  parameter int FRAC  = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  fp24              x,
  output logic [WIDTH-1:0] n
);

  logic                         sign;
  logic [FP24_EXP_W-1:0]        expo;
  logic [FP24_MANT_W:0]         mant;
  logic [WIDTH+FP24_MANT_W:0]   wide;
  int                           scale;
  logic [WIDTH-1:0]             val;

  assign sign = x[23];
  assign expo = x[22:16];
  // restore the hidden one
  assign mant = {1'b1, x[FP24_MANT_W-1:0]};

  always_comb begin
    // position of the leading one in x * 2^FRAC
    scale = int'(expo) - FP24_BIAS + FRAC;
    wide  = '0;
    if (sign || expo == '0 || scale < 0) begin
      // negative, zero or below one lsb
      val = '0;
    end else if (scale >= WIDTH) begin
      // too large for the field
      val = '1;
    end else begin
      // floor by dropping the mantissa fraction bits
      wide = (WIDTH + FP24_MANT_W + 1)'(mant) << scale;
      val  = wide[WIDTH+FP24_MANT_W-1:FP24_MANT_W];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      n <= '0;
    end else begin
      n <= val;
    end
  end

endmodule

// ==== src/rtx.sv ====
`timescale 1ns/1ps

module rtx import rtx_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  // camera
  input  fix16     cam_x,
  input  fix16     cam_y,
  input  fix16     cam_z,
  input  fix16     cam_dx,
  input  fix16     cam_dy,
  input  fix16     cam_dz,
  // scene read port
  output obj_idx_t rd_idx,
  input  logic     rd_enable,
  input  fix16     rd_cx,
  input  fix16     rd_cy,
  input  fix16     rd_cz,
  input  fix16     rd_radius,
  input  fp24      rd_r,
  input  fp24      rd_g,
  input  fp24      rd_b,
  // pixel output
  output rgb565_t  pixel,
  output pix_h_t   pixel_h,
  output pix_v_t   pixel_v,
  output logic     pixel_valid,
  input  logic     pixel_ready,
  output logic     busy
);

  logic   new_ray;
  logic   accept;
  logic   ray_valid;
  pix_h_t ray_h;
  pix_v_t ray_v;
  fix16   org_x;
  fix16   org_y;
  fix16   org_z;
  fix16   dir_x;
  fix16   dir_y;
  fix16   dir_z;
  logic   last_pixel;
  logic   trace_done;
  fp24    color_r;
  fp24    color_g;
  fp24    color_b;
  pix_h_t trace_h;
  pix_v_t trace_v;
  logic   trace_last;
  logic   trace_done_d;
  logic   last_d;
  logic [4:0] red5;
  logic [5:0] green6;
  logic [4:0] blue5;

  assign accept = pixel_valid && pixel_ready;
  // first ray on start, then one more per accepted pixel until frame end
  assign new_ray = (start && !busy) || (accept && !last_d);

  assign pixel = {blue5, green6, red5};

  ray_caster u_caster (
    .clk        (clk),
    .rst_n      (rst_n),
    .new_ray    (new_ray),
    .cam_x      (cam_x),
    .cam_y      (cam_y),
    .cam_z      (cam_z),
    .cam_dx     (cam_dx),
    .cam_dy     (cam_dy),
    .cam_dz     (cam_dz),
    .ray_valid  (ray_valid),
    .ray_h      (ray_h),
    .ray_v      (ray_v),
    .org_x      (org_x),
    .org_y      (org_y),
    .org_z      (org_z),
    .dir_x      (dir_x),
    .dir_y      (dir_y),
    .dir_z      (dir_z),
    .last_pixel (last_pixel)
  );

  ray_tracer u_tracer (
    .clk        (clk),
    .rst_n      (rst_n),
    .ray_valid  (ray_valid),
    .ray_h      (ray_h),
    .ray_v      (ray_v),
    .org_x      (org_x),
    .org_y      (org_y),
    .org_z      (org_z),
    .dir_x      (dir_x),
    .dir_y      (dir_y),
    .dir_z      (dir_z),
    .last_in    (last_pixel),
    .rd_idx     (rd_idx),
    .rd_enable  (rd_enable),
    .rd_cx      (rd_cx),
    .rd_cy      (rd_cy),
    .rd_cz      (rd_cz),
    .rd_radius  (rd_radius),
    .rd_r       (rd_r),
    .rd_g       (rd_g),
    .rd_b       (rd_b),
    .trace_done (trace_done),
    .color_r    (color_r),
    .color_g    (color_g),
    .color_b    (color_b),
    .pix_h      (trace_h),
    .pix_v      (trace_v),
    .last_out   (trace_last)
  );

  // 565 packing, one register stage
  fp24_to_uint #(.WIDTH(5), .FRAC(5)) u_conv_r (
    .clk(clk), .rst_n(rst_n), .x(color_r), .n(red5)
  );
  fp24_to_uint #(.WIDTH(6), .FRAC(6)) u_conv_g (
    .clk(clk), .rst_n(rst_n), .x(color_g), .n(green6)
  );
  fp24_to_uint #(.WIDTH(5), .FRAC(5)) u_conv_b (
    .clk(clk), .rst_n(rst_n), .x(color_b), .n(blue5)
  );

  // line up the tracer side with the converter outputs
  always_ff @(posedge clk) begin
    pixel_h <= trace_h;
    pixel_v <= trace_v;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_done_d <= 1'b0;
      last_d       <= 1'b0;
      pixel_valid  <= 1'b0;
      busy         <= 1'b0;
    end else begin
      trace_done_d <= trace_done;
      last_d       <= trace_last;
      // hold valid until the sink takes it
      if (accept) begin
        pixel_valid <= 1'b0;
      end else if (trace_done_d) begin
        pixel_valid <= 1'b1;
      end
      // frame ends when the last pixel leaves
      if (start && !busy) begin
        busy <= 1'b1;
      end else if (accept && last_d) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

// ==== src/rtx_top.sv ====
`timescale 1ns/1ps

module rtx_top import rtx_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  // camera
  input  fix16     cam_x,
  input  fix16     cam_y,
  input  fix16     cam_z,
  input  fix16     cam_dx,
  input  fix16     cam_dy,
  input  fix16     cam_dz,
  // scene write port
  input  logic     obj_we,
  input  obj_idx_t obj_addr,
  input  logic     obj_enable,
  input  fix16     obj_cx,
  input  fix16     obj_cy,
  input  fix16     obj_cz,
  input  fix16     obj_radius,
  input  fp24      obj_r,
  input  fp24      obj_g,
  input  fp24      obj_b,
  // pixel output
  output rgb565_t  pixel,
  output pix_h_t   pixel_h,
  output pix_v_t   pixel_v,
  output logic     pixel_valid,
  input  logic     pixel_ready,
  output logic     busy
);

  // scene read path between tracer and buffer
  obj_idx_t rd_idx;
  logic     rd_enable;
  fix16     rd_cx;
  fix16     rd_cy;
  fix16     rd_cz;
  fix16     rd_radius;
  fp24      rd_r;
  fp24      rd_g;
  fp24      rd_b;

  rtx u_rtx (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .cam_x       (cam_x),
    .cam_y       (cam_y),
    .cam_z       (cam_z),
    .cam_dx      (cam_dx),
    .cam_dy      (cam_dy),
    .cam_dz      (cam_dz),
    .rd_idx      (rd_idx),
    .rd_enable   (rd_enable),
    .rd_cx       (rd_cx),
    .rd_cy       (rd_cy),
    .rd_cz       (rd_cz),
    .rd_radius   (rd_radius),
    .rd_r        (rd_r),
    .rd_g        (rd_g),
    .rd_b        (rd_b),
    .pixel       (pixel),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready),
    .busy        (busy)
  );

  scene_buffer u_scene (
    .clk        (clk),
    .rst_n      (rst_n),
    .obj_we     (obj_we),
    .obj_addr   (obj_addr),
    .obj_enable (obj_enable),
    .obj_cx     (obj_cx),
    .obj_cy     (obj_cy),
    .obj_cz     (obj_cz),
    .obj_radius (obj_radius),
    .obj_r      (obj_r),
    .obj_g      (obj_g),
    .obj_b      (obj_b),
    .rd_idx     (rd_idx),
    .rd_enable  (rd_enable),
    .rd_cx      (rd_cx),
    .rd_cy      (rd_cy),
    .rd_cz      (rd_cz),
    .rd_radius  (rd_radius),
    .rd_r       (rd_r),
    .rd_g       (rd_g),
    .rd_b       (rd_b)
  );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

// free-running testbench clock, 10 ns period
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #5 clk = ~clk;
  end

endmodule

// ==== bench/rtx_tb.sv ====
`timescale 1ns/1ps

module rtx_tb import rtx_pkg::*; ();

  // start to first pixel_valid, and accepted pixel to next pixel_valid
  localparam int LATENCY    = 2 + 2 * NUM_OBJ + 2;
  localparam int WAIT_LIMIT = 200;

  logic    clk;
  logic    rst_n;
  logic    start;
  fix16    cam_x;
  fix16    cam_y;
  fix16    cam_z;
  fix16    cam_dx;
  fix16    cam_dy;
  fix16    cam_dz;
  logic    obj_we;
  obj_idx_t obj_addr;
  logic    obj_enable;
  fix16    obj_cx;
  fix16    obj_cy;
  fix16    obj_cz;
  fix16    obj_radius;
  fp24     obj_r;
  fp24     obj_g;
  fp24     obj_b;
  rgb565_t pixel;
  pix_h_t  pixel_h;
  pix_v_t  pixel_v;
  logic    pixel_valid;
  logic    pixel_ready;
  logic    busy;

  // model copy of the scene, mirrors the DUT reset
  logic m_en  [NUM_OBJ];
  fix16 m_cx  [NUM_OBJ];
  fix16 m_cy  [NUM_OBJ];
  fix16 m_cz  [NUM_OBJ];
  fix16 m_rad [NUM_OBJ];
  fp24  m_r   [NUM_OBJ];
  fp24  m_g   [NUM_OBJ];
  fp24  m_b   [NUM_OBJ];

  integer seed;
  int     n_errors;
  int     n_pixels;

  tb_clock u_clk (
    .clk(clk)
  );

  rtx_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .cam_x       (cam_x),
    .cam_y       (cam_y),
    .cam_z       (cam_z),
    .cam_dx      (cam_dx),
    .cam_dy      (cam_dy),
    .cam_dz      (cam_dz),
    .obj_we      (obj_we),
    .obj_addr    (obj_addr),
    .obj_enable  (obj_enable),
    .obj_cx      (obj_cx),
    .obj_cy      (obj_cy),
    .obj_cz      (obj_cz),
    .obj_radius  (obj_radius),
    .obj_r       (obj_r),
    .obj_g       (obj_g),
    .obj_b       (obj_b),
    .pixel       (pixel),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready),
    .busy        (busy)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %s got 0x%0h exp 0x%0h at %0t", name, got, exp, $time);
    n_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error: %s at %0t", what, $time);
    n_errors++;
  endtask

  // fatal wait failure, ends the run right away
  task automatic abort_run(input string what);
    $display("error: %s at %0t", what, $time);
    n_errors++;
    $display("pixels checked %0d, errors %0d", n_pixels, n_errors);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // floor(x * 2^frac) clamped to the field, worked out in real arithmetic
  function automatic int conv_expect(input fp24 x, input int width, input int frac);
    int  e;
    int  scale;
    int  n;
    real v;
    real lim;
    e = int'(x[22:16]);
    if (x[23] || e == 0) begin
      n = 0;
    end else begin
      v = 1.0 + x[15:0] / 65536.0;
      scale = e - 63 + frac;
      for (int i = 0; i < scale; i++) begin
        v = v * 2.0;
      end
      for (int i = 0; i < -scale; i++) begin
        v = v / 2.0;
      end
      lim = 1.0;
      for (int i = 0; i < width; i++) begin
        lim = lim * 2.0;
      end
      n = (v >= lim) ? (1 << width) - 1 : $rtoi(v);
    end
    return n;
  endfunction

  // reference ray for pixel h,v against the model scene
  function automatic rgb565_t expect_pixel(input int h, input int v);
    fix16               wdx;
    fix16               wdy;
    logic signed [95:0] dx;
    logic signed [95:0] dy;
    logic signed [95:0] dz;
    logic signed [95:0] ocx;
    logic signed [95:0] ocy;
    logic signed [95:0] ocz;
    logic signed [95:0] a;
    logic signed [95:0] b;
    logic signed [95:0] c;
    logic signed [95:0] best_a;
    logic signed [95:0] best_b;
    bit                 found;
    fp24                cr;
    fp24                cg;
    fp24                cb;
    int                 r5;
    int                 g6;
    int                 b5;
    // direction wraps in 16 bits before widening
    wdx = cam_dx + fix16'((h - IMG_W / 2) * PIXEL_STEP);
    wdy = cam_dy + fix16'((IMG_H / 2 - v) * PIXEL_STEP);
    dx = wdx;
    dy = wdy;
    dz = cam_dz;
    found = 1'b0;
    best_a = '0;
    best_b = '0;
    cr = BG_R;
    cg = BG_G;
    cb = BG_B;
    for (int i = 0; i < NUM_OBJ; i++) begin
      if (m_en[i]) begin
        ocx = m_cx[i] - cam_x;
        ocy = m_cy[i] - cam_y;
        ocz = m_cz[i] - cam_z;
        a = dx * dx + dy * dy + dz * dz;
        b = ocx * dx + ocy * dy + ocz * dz;
        c = ocx * ocx + ocy * ocy + ocz * ocz - m_rad[i] * m_rad[i];
        // in front and discriminant not negative
        if (b > 0 && b * b >= a * c) begin
          // nearer means smaller b/a, a tie keeps the earlier slot
          if (!found || b * best_a < best_b * a) begin
            found = 1'b1;
            best_a = a;
            best_b = b;
            cr = m_r[i];
            cg = m_g[i];
            cb = m_b[i];
          end
        end
      end
    end
    r5 = conv_expect(cr, 5, 5);
    g6 = conv_expect(cg, 6, 6);
    b5 = conv_expect(cb, 5, 5);
    return rgb565_t'((b5 << 11) | (g6 << 5) | r5);
  endfunction

  // one write cycle into a scene slot, model updated alongside
  task automatic write_obj(input obj_idx_t idx, input logic en, input fix16 cx,
                           input fix16 cy, input fix16 cz, input fix16 rad,
                           input fp24 r, input fp24 g, input fp24 b);
    @(negedge clk);
    obj_we     = 1'b1;
    obj_addr   = idx;
    obj_enable = en;
    obj_cx     = cx;
    obj_cy     = cy;
    obj_cz     = cz;
    obj_radius = rad;
    obj_r      = r;
    obj_g      = g;
    obj_b      = b;
    @(negedge clk);
    obj_we = 1'b0;
    m_en[idx]  = en;
    m_cx[idx]  = cx;
    m_cy[idx]  = cy;
    m_cz[idx]  = cz;
    m_rad[idx] = rad;
    m_r[idx]   = r;
    m_g[idx]   = g;
    m_b[idx]   = b;
  endtask

  // start one frame and check every pixel in raster order
  task automatic run_frame(input bit random_ready);
    int      npix;
    int      cnt;
    bit      pend;
    bit      rdy;
    rgb565_t held_pix;
    pix_h_t  held_h;
    pix_v_t  held_v;
    rgb565_t exp_pix;
    npix = 0;
    cnt  = 0;
    pend = 1'b0;
    @(negedge clk);
    start       = 1'b1;
    pixel_ready = 1'b0;
    while (npix < IMG_W * IMG_H) begin
      @(posedge clk);
      cnt++;
      @(negedge clk);
      start = 1'b0;
      if (cnt > WAIT_LIMIT) begin
        abort_run($sformatf("pixel %0d never arrived", npix));
      end
      if (busy !== 1'b1) begin
        report_failure("busy low in the middle of a frame");
      end
      if (pend) begin
        // stalled pixel must not move
        if (pixel_valid !== 1'b1) begin
          report_failure("pixel_valid dropped before the pixel was accepted");
        end
        if (pixel !== held_pix) begin
          report_mismatch("pixel", pixel, held_pix);
        end
        if (pixel_h !== held_h) begin
          report_mismatch("pixel_h", pixel_h, held_h);
        end
        if (pixel_v !== held_v) begin
          report_mismatch("pixel_v", pixel_v, held_v);
        end
      end else if (pixel_valid) begin
        exp_pix = expect_pixel(npix % IMG_W, npix / IMG_W);
        n_pixels++;
        if (cnt != LATENCY) begin
          report_failure($sformatf("pixel %0d came after %0d cycles, not %0d",
                                   npix, cnt, LATENCY));
        end
        if (pixel !== exp_pix) begin
          report_mismatch("pixel", pixel, exp_pix);
        end
        if (pixel_h !== pix_h_t'(npix % IMG_W)) begin
          report_mismatch("pixel_h", pixel_h, npix % IMG_W);
        end
        if (pixel_v !== pix_v_t'(npix / IMG_W)) begin
          report_mismatch("pixel_v", pixel_v, npix / IMG_W);
        end
      end
      if (random_ready) begin
        rdy = 1'($random(seed));
      end else begin
        rdy = 1'b1;
      end
      pixel_ready = rdy;
      // transfer happens on the coming rising edge
      if (pixel_valid && rdy) begin
        npix++;
        cnt  = 0;
        pend = 1'b0;
      end else if (pixel_valid) begin
        pend     = 1'b1;
        held_pix = pixel;
        held_h   = pixel_h;
        held_v   = pixel_v;
      end
    end
    @(posedge clk);
    @(negedge clk);
    if (busy !== 1'b0) begin
      report_failure("busy still high after the last pixel");
    end
    if (pixel_valid !== 1'b0) begin
      report_failure("pixel_valid high after the frame ended");
    end
    pixel_ready = 1'b0;
  endtask

  task automatic test_reset_state();
    if (pixel_valid !== 1'b0) begin
      report_failure("pixel_valid high after reset");
    end
    if (busy !== 1'b0) begin
      report_failure("busy high after reset");
    end
    // idle window, nothing may come out
    repeat (30) begin
      @(negedge clk);
      if (pixel_valid !== 1'b0 || busy !== 1'b0) begin
        report_failure("output activity without start");
      end
    end
  endtask

  task automatic test_empty_scene();
    cam_x  = 16'sh0000;
    cam_y  = 16'sh0000;
    cam_z  = 16'sh0000;
    cam_dx = 16'sh0000;
    cam_dy = 16'sh0000;
    cam_dz = 16'sh0100;
    run_frame(1'b0);
  endtask

  task automatic test_single_sphere();
    // radius 1.5 at z 4, partly covers the view
    write_obj(2'd0, 1'b1, 16'sh0000, 16'sh0000, 16'sh0400, 16'sh0180,
              24'h3e8000, 24'h3f0000, 24'h3d8000);
    run_frame(1'b0);
  endtask

  task automatic test_overlap();
    // far and near sphere on the camera axis
    write_obj(2'd0, 1'b1, 16'sh0000, 16'sh0000, 16'sh0600, 16'sh0200,
              24'h3e0000, 24'h3c0000, 24'h3f0000);
    write_obj(2'd1, 1'b1, 16'sh0000, 16'sh0000, 16'sh0300, 16'sh0100,
              24'h3f0000, 24'h3e0000, 24'h3c0000);
    // identical pair, slot 2 must win over slot 3
    write_obj(2'd2, 1'b1, -16'sh0140, -16'sh0100, 16'sh0400, 16'sh0080,
              24'h3d0000, 24'h3f0000, 24'h3d0000);
    write_obj(2'd3, 1'b1, -16'sh0140, -16'sh0100, 16'sh0400, 16'sh0080,
              24'h3b0000, 24'h3b0000, 24'h3b0000);
    run_frame(1'b0);
  endtask

  task automatic test_back_pressure();
    // same scene, random sink
    run_frame(1'b1);
  endtask

  task automatic test_conversion();
    write_obj(2'd1, 1'b0, 16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000,
              24'h000000, 24'h000000, 24'h000000);
    write_obj(2'd2, 1'b0, 16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000,
              24'h000000, 24'h000000, 24'h000000);
    write_obj(2'd3, 1'b0, 16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000,
              24'h000000, 24'h000000, 24'h000000);
    // big sphere fills the whole view
    // 3.5, -2.0 and zero
    write_obj(2'd0, 1'b1, 16'sh0000, 16'sh0000, 16'sh0400, 16'sh0300,
              24'h40c000, 24'hc00000, 24'h000000);
    run_frame(1'b0);
    // tiny, exactly one and just under one
    write_obj(2'd0, 1'b1, 16'sh0000, 16'sh0000, 16'sh0400, 16'sh0300,
              24'h390000, 24'h3f0000, 24'h3effff);
    run_frame(1'b0);
  endtask

  initial begin
    seed        = 22;
    n_errors    = 0;
    n_pixels    = 0;
    rst_n       = 1'b0;
    start       = 1'b0;
    cam_x       = '0;
    cam_y       = '0;
    cam_z       = '0;
    cam_dx      = '0;
    cam_dy      = '0;
    cam_dz      = '0;
    obj_we      = 1'b0;
    obj_addr    = '0;
    obj_enable  = 1'b0;
    obj_cx      = '0;
    obj_cy      = '0;
    obj_cz      = '0;
    obj_radius  = '0;
    obj_r       = '0;
    obj_g       = '0;
    obj_b       = '0;
    pixel_ready = 1'b0;
    for (int i = 0; i < NUM_OBJ; i++) begin
      m_en[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_empty_scene();
    test_single_sphere();
    test_overlap();
    test_back_pressure();
    test_conversion();
    $display("pixels checked %0d, errors %0d", n_pixels, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== rtx.f ====
src/rtx_pkg.sv
src/scene_buffer.sv
src/ray_caster.sv
src/ray_tracer.sv
src/fp24_to_uint.sv
src/rtx.sv
src/rtx_top.sv
bench/tb_clock.sv
bench/rtx_tb.sv

// ==== Bender.yml ====
package:
  name: rtx

sources:
  - src/rtx_pkg.sv
  - src/scene_buffer.sv
  - src/ray_caster.sv
  - src/ray_tracer.sv
  - src/fp24_to_uint.sv
  - src/rtx.sv
  - src/rtx_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/rtx_tb.sv
